// File: aa_bridge_top.f
+incdir+include
src/aa_pkg.sv
src/aa_ls_capture.sv
src/aa_ctrl.sv
src/aa_regfile.sv
src/aa_ss_rx.sv
src/aa_sm_tx.sv
src/aa_bridge_top.sv
tb/tb_aa_bridge.sv

// File: run.sh
#!/bin/sh
# compile with Verilator, run, and pass only when the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --assert -j 0 --top-module tb_aa_bridge -f aa_bridge_top.f &&
./obj_dir/Vtb_aa_bridge | tee /dev/stderr | grep -q -F '*** TEST PASSED ***' &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

// File: tb/tb_aa_bridge.sv
`include "aa_bridge_defines.svh"

module tb_aa_bridge;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_NS          = 8;
  localparam int RST_CYCLES      = 16;
  localparam int CYCLES_PER_TEST = 200;
  localparam int N_TESTS         = 6;

  // one beat taken by the stream master sink
  typedef struct packed {
    aa_pkg::data_t  tdata;
    aa_pkg::strb_t  tstrb;
    aa_pkg::tuser_e tuser;
  } sm_beat_t;

  logic             axis_clk;
  logic             axis_rst_n;
  logic             s_awvalid, s_wvalid, s_arvalid, s_rready;
  logic             s_awready, s_wready, s_arready, s_rvalid;
  aa_pkg::ls_addr_t s_awaddr, s_araddr;
  aa_pkg::data_t    s_wdata, s_rdata;
  aa_pkg::strb_t    s_wstrb;
  aa_pkg::data_t    aa_as_tdata, as_aa_tdata;
  aa_pkg::strb_t    aa_as_tstrb;
  aa_pkg::tuser_e   aa_as_tuser, as_aa_tuser;
  logic             aa_as_tvalid, as_aa_tready, as_aa_tvalid, aa_as_tready;
  logic             cc_aa_enable, mb_irq;

  int       errors = 0;
  logic     stall_en = 1'b0;
  sm_beat_t sm_q[$];

  aa_bridge_top dut0 (.*);

  // --------------------------------------------------
  // clock, watchdog and remote-side models
  // --------------------------------------------------
  initial begin
    axis_clk = 1'b0;
    forever #(CLK_NS / 2) axis_clk = ~axis_clk;
  end

  initial begin
    #(CLK_NS * (RST_CYCLES + CYCLES_PER_TEST * N_TESTS));
    $display("ERROR: watchdog expired, a handshake never completed (errors %0d)", errors);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // sm sink stalls tready at random while stall_en is set
  initial begin
    as_aa_tready = 1'b1;
    forever begin
      @(posedge axis_clk);
      as_aa_tready <= stall_en ? (($urandom % 3) != 0) : 1'b1;
    end
  end

  // record a beat before the edge that takes it
  initial begin
    sm_beat_t rec;
    forever begin
      @(negedge axis_clk);
      if (aa_as_tvalid && as_aa_tready) begin
        rec.tdata = aa_as_tdata;
        rec.tstrb = aa_as_tstrb;
        rec.tuser = aa_as_tuser;
        sm_q.push_back(rec);
      end
    end
  end

  // --------------------------------------------------
  // protocol assertions
  // --------------------------------------------------
  a_disabled_quiet: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    !cc_aa_enable |-> !s_awready && !s_arready)
    else begin
      errors++;
      $display("ERROR: LS ready raised while cc_aa_enable was low");
    end

  a_aw_w_pair: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    s_awready == s_wready)
    else begin
      errors++;
      $display("ERROR: s_awready and s_wready were not raised together");
    end

  a_rvalid_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata))
    else begin
      errors++;
      $display("ERROR: read response dropped or changed before s_rready");
    end

  a_sm_stable: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    aa_as_tvalid && !as_aa_tready |=> aa_as_tvalid && $stable(aa_as_tdata))
    else begin
      errors++;
      $display("ERROR: stream master beat dropped or changed under back-pressure");
    end

  // --------------------------------------------------
  // helpers are entered just after a rising edge
  // --------------------------------------------------
  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else begin
        errors++;
        $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
  endtask

  // beat 1 layout {strobe, zero-extended address}
  function automatic aa_pkg::data_t addr_beat(aa_pkg::strb_t strb, aa_pkg::ls_addr_t addr);
    return {strb, {(`AA_FWD_ADDR_W-`AA_LS_ADDR_W){1'b0}}, addr};
  endfunction

  task automatic axil_write(input aa_pkg::ls_addr_t addr, input aa_pkg::data_t data,
                            input aa_pkg::strb_t strb, output int beats_at_ready);
    s_awvalid <= 1'b1;
    s_awaddr  <= addr;
    s_wvalid  <= 1'b1;
    s_wdata   <= data;
    s_wstrb   <= strb;
    @(negedge axis_clk);
    while (!s_awready) @(negedge axis_clk);
    beats_at_ready = sm_q.size();
    @(posedge axis_clk);
    s_awvalid <= 1'b0;
    s_wvalid  <= 1'b0;
  endtask

  task automatic axil_read(input aa_pkg::ls_addr_t addr, output aa_pkg::data_t data);
    int gap;
    gap = $urandom % 4;
    s_arvalid <= 1'b1;
    s_araddr  <= addr;
    @(negedge axis_clk);
    while (!s_arready) @(negedge axis_clk);
    @(posedge axis_clk);
    s_arvalid <= 1'b0;
    @(negedge axis_clk);
    while (!s_rvalid) @(negedge axis_clk);
    data = s_rdata;
    // rready held back a few cycles
    repeat (gap) @(posedge axis_clk);
    @(posedge axis_clk);
    s_rready <= 1'b1;
    @(posedge axis_clk);
    s_rready <= 1'b0;
  endtask

  task automatic send_beat(input aa_pkg::tuser_e user, input aa_pkg::data_t data);
    as_aa_tvalid <= 1'b1;
    as_aa_tuser  <= user;
    as_aa_tdata  <= data;
    @(negedge axis_clk);
    while (!aa_as_tready) @(negedge axis_clk);
    @(posedge axis_clk);
    as_aa_tvalid <= 1'b0;
  endtask

  task automatic remote_write(input logic [`AA_FWD_ADDR_W-1:0] addr,
                              input aa_pkg::strb_t strb, input aa_pkg::data_t data);
    send_beat(aa_pkg::WRITE, {strb, addr});
    send_beat(aa_pkg::WRITE, data);
    // write lands on the commit edge
    @(posedge axis_clk);
  endtask

  task automatic wait_beats(input int n);
    @(negedge axis_clk);
    while (sm_q.size() < n) @(negedge axis_clk);
  endtask

  task automatic check_beat(input aa_pkg::data_t exp_data, input aa_pkg::strb_t exp_strb,
                            input aa_pkg::tuser_e exp_user);
    sm_beat_t b;
    if (sm_q.size() == 0) begin
      errors++;
      $display("ERROR: expected a stream master beat but none was sent");
    end else begin
      b = sm_q.pop_front();
      expect_eq("aa_as_tdata", b.tdata, exp_data);
      expect_eq("aa_as_tstrb", 32'(b.tstrb), 32'(exp_strb));
      expect_eq("aa_as_tuser", 32'(b.tuser), 32'(exp_user));
    end
  endtask

  task automatic check_write_beats(input aa_pkg::ls_addr_t addr, input aa_pkg::data_t data,
                                   input aa_pkg::strb_t strb);
    wait_beats(2);
    check_beat(addr_beat(strb, addr), strb, aa_pkg::WRITE);
    check_beat(data, strb, aa_pkg::WRITE);
    @(posedge axis_clk);
  endtask

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  initial begin
    aa_pkg::data_t rd;
    aa_pkg::data_t cpl;
    aa_pkg::data_t mbox_val;
    aa_pkg::data_t rnd;
    int            n;
    rnd = $urandom(51198);
    axis_rst_n   = 1'b0;
    cc_aa_enable = 1'b1;
    s_awvalid    = 1'b0;
    s_awaddr     = '0;
    s_wvalid     = 1'b0;
    s_wdata      = '0;
    s_wstrb      = '0;
    s_arvalid    = 1'b0;
    s_araddr     = '0;
    s_rready     = 1'b0;
    as_aa_tvalid = 1'b0;
    as_aa_tdata  = '0;
    as_aa_tuser  = aa_pkg::PLAIN;
    repeat (RST_CYCLES) @(posedge axis_clk);
    axis_rst_n <= 1'b1;
    @(negedge axis_clk);
    expect_eq("s_awready", 32'(s_awready), 32'h0);
    expect_eq("s_arready", 32'(s_arready), 32'h0);
    expect_eq("s_rvalid", 32'(s_rvalid), 32'h0);
    expect_eq("aa_as_tvalid", 32'(aa_as_tvalid), 32'h0);
    expect_eq("mb_irq", 32'(mb_irq), 32'h0);
    expect_eq("aa_as_tready", 32'(aa_as_tready), 32'h1);
    @(posedge axis_clk);

    // full then strobed write to local mailbox word 3, both mirrored
    axil_write(15'h200C, 32'h11223344, 4'hF, n);
    check_write_beats(15'h200C, 32'h11223344, 4'hF);
    axil_write(15'h200C, 32'hAABBCCDD, 4'b0101, n);
    expect_eq("beats before s_awready", n, 32'h0);
    check_write_beats(15'h200C, 32'hAABBCCDD, 4'b0101);
    @(posedge axis_clk);
    axil_read(15'h200C, rd);
    expect_eq("s_rdata", rd, 32'h11BB33DD);

    // forwarded write under tready stalls
    stall_en <= 1'b1;
    rnd = $urandom;
    axil_write(15'h4010, rnd, rnd[3:0], n);
    expect_eq("beats before s_awready", n, 32'h2);
    repeat (4) @(posedge axis_clk);
    expect_eq("sm beat count", sm_q.size(), 32'h2);
    check_write_beats(15'h4010, rnd, rnd[3:0]);

    // forwarded read answered by the ss model after the request beat
    cpl = $urandom;
    fork
      axil_read(15'h5A24, rd);
      begin
        wait_beats(1);
        @(posedge axis_clk);
        send_beat(aa_pkg::READ_CPL, cpl);
      end
    join
    check_beat(addr_beat(4'h0, 15'h5A24), 4'hF, aa_pkg::READ_REQ);
    expect_eq("s_rdata", rd, cpl);
    stall_en <= 1'b0;

    // remote enable and mailbox writes raise the irq
    remote_write({`AA_SS_REG_PAGE, 8'h00}, 4'h1, 32'h1);
    @(negedge axis_clk);
    expect_eq("mb_irq", 32'(mb_irq), 32'h0);
    @(posedge axis_clk);
    mbox_val = $urandom;
    remote_write({`AA_SS_MBOX_PAGE, 8'h14}, 4'hF, mbox_val);
    @(negedge axis_clk);
    expect_eq("mb_irq", 32'(mb_irq), 32'h1);
    @(posedge axis_clk);
    axil_read(15'h2014, rd);
    expect_eq("s_rdata", rd, mbox_val);
    axil_write(15'h2104, 32'h1, 4'h1, n);
    @(negedge axis_clk);
    expect_eq("mb_irq", 32'(mb_irq), 32'h0);
    @(posedge axis_clk);

    // plain and read request beats and a foreign page write leave registers alone
    send_beat(aa_pkg::PLAIN, {4'hF, `AA_SS_MBOX_PAGE, 8'h14});
    send_beat(aa_pkg::PLAIN, $urandom);
    send_beat(aa_pkg::READ_REQ, {4'hF, `AA_SS_REG_PAGE, 8'h04});
    remote_write({20'h00030, 8'h14}, 4'hF, $urandom);
    axil_read(15'h2014, rd);
    expect_eq("s_rdata", rd, mbox_val);
    axil_read(15'h2104, rd);
    expect_eq("s_rdata", rd, 32'h0);
    expect_eq("mb_irq", 32'(mb_irq), 32'h0);

    // requests held off while the bridge is disabled
    cc_aa_enable <= 1'b0;
    @(posedge axis_clk);
    fork
      axil_write(15'h2100, 32'h0, 4'h1, n);
      begin
        repeat (20) @(posedge axis_clk);
        cc_aa_enable <= 1'b1;
      end
    join
    cc_aa_enable <= 1'b0;
    @(posedge axis_clk);
    fork
      axil_read(15'h2100, rd);
      begin
        repeat (20) @(posedge axis_clk);
        cc_aa_enable <= 1'b1;
      end
    join
    expect_eq("s_rdata", rd, 32'h0);

    repeat (4) @(posedge axis_clk);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: src/aa_bridge_top.sv
`include "aa_bridge_defines.svh"

module aa_bridge_top (
  input  logic                     axis_clk,
  input  logic                     axis_rst_n,
  // --------------------------------------------------
  // axi-lite slave
  // --------------------------------------------------
  input  logic                     s_awvalid,
  input  logic [`AA_LS_ADDR_W-1:0] s_awaddr,
  output logic                     s_awready,
  input  logic                     s_wvalid,
  input  logic [`AA_DATA_W-1:0]    s_wdata,
  input  logic [`AA_STRB_W-1:0]    s_wstrb,
  output logic                     s_wready,
  input  logic                     s_arvalid,
  input  logic [`AA_LS_ADDR_W-1:0] s_araddr,
  output logic                     s_arready,
  output logic [`AA_DATA_W-1:0]    s_rdata,
  output logic                     s_rvalid,
  input  logic                     s_rready,
  // stream master
  output logic [`AA_DATA_W-1:0]    aa_as_tdata,
  output logic [`AA_STRB_W-1:0]    aa_as_tstrb,
  output aa_pkg::tuser_e           aa_as_tuser,
  output logic                     aa_as_tvalid,
  input  logic                     as_aa_tready,
  // stream slave
  input  logic [`AA_DATA_W-1:0]    as_aa_tdata,
  input  aa_pkg::tuser_e           as_aa_tuser,
  input  logic                     as_aa_tvalid,
  output logic                     aa_as_tready,
  // misc
  input  logic                     cc_aa_enable,
  output logic                     mb_irq
);

  aa_pkg::ls_req_t req;
  aa_pkg::rf_wr_t  ss_wr;
  aa_pkg::data_t   cpl_data;
  logic            is_local_reg;
  logic            is_local_mbox;
  logic            capture_en;
  logic            ls_wr_commit;
  logic            rd_wait;
  logic            ss_busy;
  logic            cpl_valid;
  logic [1:0]      beat;

  aa_ctrl u_ctrl (.*);

  aa_ls_capture u_ls_capture (.*);

  // read mux picks local data for either window page
  aa_regfile u_regfile (.*, .is_local(is_local_reg | is_local_mbox));

  aa_ss_rx u_ss_rx (.*);

  aa_sm_tx u_sm_tx (.*);

endmodule

// File: src/aa_sm_tx.sv
`include "aa_bridge_defines.svh"

module aa_sm_tx (
  input  aa_pkg::ls_req_t req,
  input  logic [1:0]      beat,
  output aa_pkg::data_t   aa_as_tdata,
  output aa_pkg::strb_t   aa_as_tstrb,
  output aa_pkg::tuser_e  aa_as_tuser
);

  logic [`AA_FWD_ADDR_W-1:0] fwd_addr;

  // ls address widened to the stream address field
  assign fwd_addr = {{(`AA_FWD_ADDR_W-`AA_LS_ADDR_W){1'b0}}, req.addr};

  // --------------------------------------------------
  // beat build
  // --------------------------------------------------
  always_comb begin
    case (beat)
      aa_pkg::BEAT_WR1: begin
        aa_as_tdata = {req.wstrb, fwd_addr};
        aa_as_tuser = aa_pkg::WRITE;
      end
      aa_pkg::BEAT_WR2: begin
        aa_as_tdata = req.wdata;
        aa_as_tuser = aa_pkg::WRITE;
      end
      // read request has no strobe nibble
      aa_pkg::BEAT_RREQ: begin
        aa_as_tdata = {{`AA_STRB_W{1'b0}}, fwd_addr};
        aa_as_tuser = aa_pkg::READ_REQ;
      end
      default: begin
        aa_as_tdata = '0;
        aa_as_tuser = aa_pkg::PLAIN;
      end
    endcase
  end

  assign aa_as_tstrb = (beat == aa_pkg::BEAT_RREQ) ? '1 : req.wstrb;

endmodule

// File: src/aa_ss_rx.sv
`include "aa_bridge_defines.svh"

module aa_ss_rx (
  input  logic           axis_clk,
  input  logic           axis_rst_n,
  input  aa_pkg::data_t  as_aa_tdata,
  input  aa_pkg::tuser_e as_aa_tuser,
  input  logic           as_aa_tvalid,
  input  logic           rd_wait,
  output logic           aa_as_tready,
  output logic           ss_busy,
  output aa_pkg::rf_wr_t ss_wr,
  output logic           cpl_valid,
  output aa_pkg::data_t  cpl_data
);

  aa_pkg::rx_state_e state;
  aa_pkg::mbox_idx_t r_idx;
  aa_pkg::strb_t     r_wstrb;
  aa_pkg::data_t     r_wdata;
  logic              r_hit_reg;
  logic              r_hit_mbox;
  logic              r_sel_status;
  logic              wr_start;

  // --------------------------------------------------
  // beat sequencing
  // --------------------------------------------------
  assign wr_start  = (state == aa_pkg::RX_IDLE) & as_aa_tvalid &
                     (as_aa_tuser == aa_pkg::WRITE);
  // completion only counts while a read is outstanding
  assign cpl_valid = (state == aa_pkg::RX_IDLE) & as_aa_tvalid & rd_wait &
                     (as_aa_tuser == aa_pkg::READ_CPL);

  // paused for the commit cycle only
  assign aa_as_tready = (state != aa_pkg::RX_COMMIT);
  // an arriving write blocks ctrl too
  assign ss_busy      = (state != aa_pkg::RX_IDLE) | wr_start;

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      state <= aa_pkg::RX_IDLE;
    end else begin
      case (state)
        aa_pkg::RX_IDLE:   if (wr_start) state <= aa_pkg::RX_DATA;
        aa_pkg::RX_DATA:   if (as_aa_tvalid) state <= aa_pkg::RX_COMMIT;
        default:           state <= aa_pkg::RX_IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // address, data and completion latches
  // --------------------------------------------------
  // beat 1 is {strobe, page, offset}
  always_ff @(posedge axis_clk) begin
    if (wr_start) begin
      r_wstrb      <= as_aa_tdata[31:28];
      r_hit_reg    <= (as_aa_tdata[`AA_FWD_ADDR_W-1:8] == `AA_SS_REG_PAGE);
      r_hit_mbox   <= (as_aa_tdata[`AA_FWD_ADDR_W-1:8] == `AA_SS_MBOX_PAGE);
      r_idx        <= as_aa_tdata[2 +: `AA_MBOX_IDX_W];
      r_sel_status <= as_aa_tdata[2];
    end
    if ((state == aa_pkg::RX_DATA) && as_aa_tvalid) r_wdata <= as_aa_tdata;
    if (cpl_valid) cpl_data <= as_aa_tdata;
  end

  // writes outside the bridge pages are dropped here
  assign ss_wr.en         = (state == aa_pkg::RX_COMMIT) & (r_hit_reg | r_hit_mbox);
  assign ss_wr.is_reg     = r_hit_reg;
  assign ss_wr.idx        = r_idx;
  assign ss_wr.sel_status = r_sel_status;
  assign ss_wr.wdata      = r_wdata;
  assign ss_wr.wstrb      = r_wstrb;

endmodule

// File: src/aa_regfile.sv
`include "aa_bridge_defines.svh"

module aa_regfile (
  input  logic            axis_clk,
  input  logic            axis_rst_n,
  input  aa_pkg::ls_req_t req,
  input  logic            ls_wr_commit,
  input  aa_pkg::rf_wr_t  ss_wr,
  input  aa_pkg::data_t   cpl_data,
  input  logic            is_local,
  output aa_pkg::data_t   s_rdata,
  output logic            mb_irq
);

  aa_pkg::rf_wr_t ls_wr;
  aa_pkg::rf_wr_t wr_sel;
  aa_pkg::data_t  mbox [`AA_MBOX_DEPTH];
  aa_pkg::data_t  mbox_wdata;
  aa_pkg::data_t  local_rdata;
  logic           intr_enable;
  logic           intr_status;

  // --------------------------------------------------
  // write ports
  // --------------------------------------------------
  // ls port only writes when the latched address is local
  assign ls_wr.en         = ls_wr_commit & is_local;
  assign ls_wr.is_reg     = (req.addr[11:8] == `AA_WIN_REG);
  assign ls_wr.idx        = req.addr[2 +: `AA_MBOX_IDX_W];
  assign ls_wr.sel_status = req.addr[2];
  assign ls_wr.wdata      = req.wdata;
  assign ls_wr.wstrb      = req.wstrb;

  // local side has priority
  assign wr_sel = ls_wr.en ? ls_wr : ss_wr;

  // byte merge into the addressed mailbox word
  always_comb begin
    mbox_wdata = mbox[wr_sel.idx];
    for (int b = 0; b < `AA_STRB_W; b++) begin
      if (wr_sel.wstrb[b]) mbox_wdata[8*b +: 8] = wr_sel.wdata[8*b +: 8];
    end
  end

  always_ff @(posedge axis_clk) begin
    if (wr_sel.en && !wr_sel.is_reg) mbox[wr_sel.idx] <= mbox_wdata;
  end

  // --------------------------------------------------
  // interrupt registers
  // --------------------------------------------------
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      intr_enable <= 1'b0;
      intr_status <= 1'b0;
    end else begin
      // enable at offset 0, writable from either side
      if (wr_sel.en && wr_sel.is_reg && !wr_sel.sel_status && wr_sel.wstrb[0])
        intr_enable <= wr_sel.wdata[0];
      // status at offset 4, write one to clear from local side
      if (ls_wr.en && ls_wr.is_reg && ls_wr.sel_status && ls_wr.wstrb[0] && ls_wr.wdata[0])
        intr_status <= 1'b0;
      // any strobed remote mailbox write raises it
      else if (ss_wr.en && !ss_wr.is_reg && (|ss_wr.wstrb))
        intr_status <= 1'b1;
    end
  end

  assign mb_irq = intr_status & intr_enable;

  // --------------------------------------------------
  // read mux
  // --------------------------------------------------
  assign local_rdata = ls_wr.is_reg ? {{(`AA_DATA_W-1){1'b0}},
                                       (req.addr[2] ? intr_status : intr_enable)}
                                    : mbox[req.addr[2 +: `AA_MBOX_IDX_W]];

  // completion data for forwarded reads
  assign s_rdata = is_local ? local_rdata : cpl_data;

  // ls and ss transactions are kept apart by ctrl and ss_rx
  a_one_writer: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    !(ls_wr.en && ss_wr.en));

endmodule

// File: src/aa_ctrl.sv
module aa_ctrl (
  input  logic            axis_clk,
  input  logic            axis_rst_n,
  input  logic            cc_aa_enable,
  input  logic            s_awvalid,
  input  logic            s_wvalid,
  input  logic            s_arvalid,
  input  logic            s_rready,
  input  logic            as_aa_tready,
  input  logic            is_local_reg,
  input  logic            is_local_mbox,
  input  aa_pkg::ls_req_t req,
  input  logic            ss_busy,
  input  logic            cpl_valid,
  output logic            capture_en,
  output logic            ls_wr_commit,
  output logic            rd_wait,
  output logic            s_awready,
  output logic            s_wready,
  output logic            s_arready,
  output logic            s_rvalid,
  output logic            aa_as_tvalid,
  output logic [1:0]      beat
);

  aa_pkg::ls_state_e state;
  aa_pkg::ls_state_e state_nxt;
  logic              start;

  // --------------------------------------------------
  // request qualification
  // --------------------------------------------------
  // write needs both aw and w, a read only starts without a pending aw
  // remote write in flight holds off a new local transaction
  assign start = cc_aa_enable & ~ss_busy &
                 ((s_awvalid & s_wvalid) | (s_arvalid & ~s_awvalid));

  // capture on the accepting edge
  assign capture_en = (state == aa_pkg::IDLE) & start;

  // --------------------------------------------------
  // state machine
  // --------------------------------------------------
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      state <= aa_pkg::IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      aa_pkg::IDLE:
        if (start) state_nxt = aa_pkg::DECODE;
      // request is latched, route by window
      aa_pkg::DECODE:
        if (req.wr) begin
          if (is_local_reg)       state_nxt = aa_pkg::WR_DONE;
          else if (is_local_mbox) state_nxt = aa_pkg::MBOX_DONE;
          else                    state_nxt = aa_pkg::SM_WR1;
        end else begin
          if (is_local_reg || is_local_mbox) state_nxt = aa_pkg::RD_DONE;
          else                               state_nxt = aa_pkg::SM_RREQ;
        end
      aa_pkg::WR_DONE:
        state_nxt = aa_pkg::IDLE;
      // local mailbox write completes, then mirrors out
      aa_pkg::MBOX_DONE:
        state_nxt = aa_pkg::SM_WR1;
      aa_pkg::SM_WR1:
        if (as_aa_tready) state_nxt = aa_pkg::SM_WR2;
      // mirrored write was already answered on ls
      aa_pkg::SM_WR2:
        if (as_aa_tready) state_nxt = is_local_mbox ? aa_pkg::IDLE : aa_pkg::WR_DONE;
      aa_pkg::SM_RREQ:
        if (as_aa_tready) state_nxt = aa_pkg::WAIT_CPL;
      aa_pkg::WAIT_CPL:
        if (cpl_valid) state_nxt = aa_pkg::RD_DONE;
      // rvalid holds until the master takes it
      aa_pkg::RD_DONE:
        if (s_rready) state_nxt = aa_pkg::IDLE;
      default:
        state_nxt = aa_pkg::IDLE;
    endcase
  end

  // --------------------------------------------------
  // ls handshake
  // --------------------------------------------------
  assign s_awready    = (state == aa_pkg::WR_DONE) | (state == aa_pkg::MBOX_DONE);
  assign s_wready     = s_awready;
  // regfile ignores the commit for forwarded writes
  assign ls_wr_commit = s_awready;
  // read address taken once it is latched
  assign s_arready    = (state == aa_pkg::DECODE) & ~req.wr;
  assign s_rvalid     = (state == aa_pkg::RD_DONE);
  assign rd_wait      = (state == aa_pkg::WAIT_CPL);

  // --------------------------------------------------
  // sm beat select
  // --------------------------------------------------
  always_comb begin
    case (state)
      aa_pkg::SM_WR1:  beat = aa_pkg::BEAT_WR1;
      aa_pkg::SM_WR2:  beat = aa_pkg::BEAT_WR2;
      aa_pkg::SM_RREQ: beat = aa_pkg::BEAT_RREQ;
      default:         beat = aa_pkg::BEAT_IDLE;
    endcase
  end

  assign aa_as_tvalid = (beat != aa_pkg::BEAT_IDLE);

  // offered beat stays up and unchanged until the switch takes it
  a_sm_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    aa_as_tvalid && !as_aa_tready |=> aa_as_tvalid && $stable(beat));

endmodule

// File: src/aa_ls_capture.sv
`include "aa_bridge_defines.svh"

module aa_ls_capture (
  input  logic             axis_clk,
  input  logic             capture_en,
  input  logic             s_awvalid,
  input  aa_pkg::ls_addr_t s_awaddr,
  input  aa_pkg::ls_addr_t s_araddr,
  input  aa_pkg::data_t    s_wdata,
  input  aa_pkg::strb_t    s_wstrb,
  output aa_pkg::ls_req_t  req,
  output logic             is_local_reg,
  output logic             is_local_mbox
);

  // --------------------------------------------------
  // request latch
  // --------------------------------------------------
  // write wins when aw is up, else the read address
  always_ff @(posedge axis_clk) begin
    if (capture_en) begin
      req.wr    <= s_awvalid;
      req.addr  <= s_awvalid ? s_awaddr : s_araddr;
      req.wdata <= s_wdata;
      req.wstrb <= s_wstrb;
    end
  end

  // local window decode from the held address
  assign is_local_reg  = (req.addr[14:12] == `AA_LS_WIN) &&
                         (req.addr[11:8] == `AA_WIN_REG);
  assign is_local_mbox = (req.addr[14:12] == `AA_LS_WIN) &&
                         (req.addr[11:8] == `AA_WIN_MBOX);

endmodule

// File: src/aa_pkg.sv
`include "aa_bridge_defines.svh"

package aa_pkg;

  // --------------------------------------------------
  // plain vector types
  // --------------------------------------------------
  typedef logic [`AA_DATA_W-1:0]     data_t;
  typedef logic [`AA_STRB_W-1:0]     strb_t;
  typedef logic [`AA_LS_ADDR_W-1:0]  ls_addr_t;
  typedef logic [`AA_MBOX_IDX_W-1:0] mbox_idx_t;

  // stream cycle type carried on tuser
  typedef enum logic [1:0] {
    PLAIN    = 2'b00,
    WRITE    = 2'b01,
    READ_REQ = 2'b10,
    READ_CPL = 2'b11
  } tuser_e;

  // ls transaction fsm
  typedef enum logic [3:0] {
    IDLE, DECODE, WR_DONE, RD_DONE, MBOX_DONE, SM_WR1, SM_WR2, SM_RREQ, WAIT_CPL
  } ls_state_e;

  // ss write sequencer
  typedef enum logic [1:0] {RX_IDLE, RX_DATA, RX_COMMIT} rx_state_e;

  // sm beat selector codes
  localparam logic [1:0] BEAT_IDLE = 2'd0;
  localparam logic [1:0] BEAT_WR1  = 2'd1;
  localparam logic [1:0] BEAT_WR2  = 2'd2;
  localparam logic [1:0] BEAT_RREQ = 2'd3;

  // latched ls request
  typedef struct packed {
    logic     wr;
    ls_addr_t addr;
    data_t    wdata;
    strb_t    wstrb;
  } ls_req_t;

  // one register file write port
  typedef struct packed {
    logic      en;
    logic      is_reg;
    mbox_idx_t idx;
    logic      sel_status;
    data_t     wdata;
    strb_t     wstrb;
  } rf_wr_t;

endpackage

// File: include/aa_bridge_defines.svh
`ifndef AA_BRIDGE_DEFINES_SVH
`define AA_BRIDGE_DEFINES_SVH

// --------------------------------------------------
// bus widths
// --------------------------------------------------
`define AA_DATA_W      32
`define AA_STRB_W      4
`define AA_LS_ADDR_W   15
// address field carried in stream beat 1, strobe sits above it
`define AA_FWD_ADDR_W  28

// mailbox of eight words, indexed by address bits 4..2
`define AA_MBOX_DEPTH  8
`define AA_MBOX_IDX_W  3

// local window on ls address bits 14..12, page on bits 11..8
`define AA_LS_WIN      3'b010
`define AA_WIN_REG     4'h1
`define AA_WIN_MBOX    4'h0

// stream address page on bits 27..8
`define AA_SS_REG_PAGE  20'h00021
`define AA_SS_MBOX_PAGE 20'h00020

`endif
